// File: project.f
logic/core_shell_pkg.sv
logic/rom_loader.sv
logic/rom_store.sv
logic/reset_sequencer.sv
logic/dip_mapper.sv
logic/input_packer.sv
logic/core_shell.sv
dv/core_shell_tb.sv

// File: Bender.yml
package:
  name: core_shell

sources:
  - files:
      - logic/core_shell_pkg.sv
      - logic/rom_loader.sv
      - logic/rom_store.sv
      - logic/reset_sequencer.sv
      - logic/dip_mapper.sv
      - logic/input_packer.sv
      - logic/core_shell.sv

  - target: simulation
    files:
      - dv/core_shell_tb.sv

// File: dv/core_shell_tb.sv
`timescale 1ns/1ps

module core_shell_tb import core_shell_pkg::*; ();

	localparam int CLK_NS      = 20;
	localparam int NUM_BYTES   = 256;
	localparam int NUM_READS   = 300;
	localparam int NUM_DIP     = 40;
	localparam int NUM_JOY     = 40;
	localparam int TEST_CYCLES = 8 + 8 + NUM_BYTES * 13 + 8 + NUM_READS + 2 + 16
		+ NUM_DIP + 2 + NUM_JOY + 2;
	localparam int TIMEOUT_NS  = TEST_CYCLES * 3 / 2 * CLK_NS;

	logic                       clock_48 = 1'b0;
	logic                       arst_n;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [ROM_BYTE_ADDR_W-1:0] ioctl_addr;
	logic [7:0]                 ioctl_dout;
	logic [31:0]                status;
	logic [6:0]                 core_mod;
	logic                       reset_button;
	logic [7:0]                 joystick_0;
	logic [7:0]                 joystick_1;
	logic [ROM_BYTE_ADDR_W-1:0] rom_addr;
	logic [7:0]                 rom_data;
	logic                       core_reset;
	logic [7:0]                 dsw0;
	logic [7:0]                 dsw1;
	logic [7:0]                 dsw2;
	logic [5:0]                 inp0;
	logic [5:0]                 inp1;
	logic [2:0]                 inp2;

	logic [31:0] lfsr = 32'h639;
	logic [7:0] rom_model [1 << ROM_BYTE_ADDR_W]; // Unwritten bytes stay X
	logic [ROM_BYTE_ADDR_W-1:0] written [NUM_BYTES];
	int checks = 0;
	int errors = 0;

	core_shell dut (
		.clock_48       (clock_48),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status         (status),
		.core_mod       (core_mod),
		.reset_button   (reset_button),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.core_reset     (core_reset),
		.dsw0           (dsw0),
		.dsw1           (dsw1),
		.dsw2           (dsw2),
		.inp0           (inp0),
		.inp1           (inp1),
		.inp2           (inp2)
	);

	always #(CLK_NS / 2) clock_48 = ~clock_48;

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Packed as {dsw2, dsw1, dsw0}
	function automatic logic [23:0] expected_dsw(input logic [6:0] mod, input logic [31:0] st);
		game_variant_e v;
		logic [7:0] d0;
		logic [7:0] d1;
		logic [7:0] d2;
		d0 = 8'd0;
		d1 = 8'd0;
		d2 = 8'd0;
		if (mod <= 7'd1)
			v = GAME_DRUAGA;
		else if (mod == 7'd2)
			v = GAME_MAPPY;
		else if (mod == 7'd3)
			v = GAME_DIGDUG2;
		else if (mod == 7'd4)
			v = GAME_MOTOS;
		else
			v = GAME_OTHER;
		case (v)
			GAME_DRUAGA: begin
				d0[5:4] = st[ST_TLIVES_LO +: 2];
				d1[0]   = st[ST_FREEZE];
				d2[7:4] = d1[3:0];
				d2[3]   = st[ST_SERVICE];
			end
			GAME_MAPPY: begin
				d0[7]   = st[ST_FREEZE];
				d0[6]   = st[ST_MROUNDP];
				d0[5]   = st[ST_MDEMO];
				d0[2:0] = st[ST_MRANK_LO +: 3];
				d1[7:6] = st[ST_MLIVES_LO +: 2];
				d1[5:3] = st[ST_MEXTEND_LO +: 3];
				d2[7]   = st[ST_SERVICE];
				d2[3]   = st[ST_SERVICE];
			end
			GAME_DIGDUG2: begin
				d0[5]   = st[ST_DLIVES];
				d1[3]   = st[ST_FREEZE];
				d1[2]   = st[ST_DLEVEL];
				d1[1:0] = st[ST_DEXTEND_LO +: 2];
				d2[7:4] = d1[3:0];
				d2[3]   = st[ST_SERVICE];
			end
			GAME_MOTOS: begin
				d0[7]   = st[ST_ODEMO];
				d0[6:5] = st[ST_OEXTEND_LO +: 2];
				d0[4]   = st[ST_ORANK];
				d0[3]   = st[ST_OLIVES];
				d1[7]   = st[ST_SERVICE];
			end
			default: ;
		endcase
		return {d2, d1, d0};
	endfunction

	// Game view {fire B, fire A, left, down, right, up}
	function automatic logic [5:0] expected_player(input logic [7:0] j, input logic rot);
		if (rot)
			return {j[5], j[4], j[3], j[1], j[2], j[0]};
		return {j[5], j[4], j[1], j[2], j[0], j[3]};
	endfunction

	function automatic logic [2:0] expected_buttons(input logic [7:0] p1, input logic [7:0] p2);
		logic [2:0] b;
		b[0] = p1[7]; // Start, player one
		b[1] = p2[7];
		b[2] = p1[6] || p2[6]; // Either coin
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic run_download();
		logic [ROM_BYTE_ADDR_W-1:0] a;
		logic [7:0] d;
		int gap;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clock_48);
		for (int i = 0; i < NUM_BYTES; i++) begin
			if (i % 16 == 15)
				a = written[rand_bits(8) % i]; // Overwrite an earlier byte
			else
				a = rand_bits(ROM_BYTE_ADDR_W);
			d = rand_bits(8);
			written[i] = a;
			rom_model[a] = d;
			ioctl_addr = a;
			ioctl_dout = d;
			ioctl_wr = 1'b1;
			@(negedge clock_48);
			ioctl_wr = 1'b0;
			gap = 6 + rand_bits(3) % 7;
			repeat (gap - 1) @(negedge clock_48);
		end
		check_value("core_reset", core_reset, 1'b1);
		ioctl_download = 1'b0;
		@(negedge clock_48);
		check_value("core_reset", core_reset, 1'b1);
		@(negedge clock_48);
		check_value("core_reset", core_reset, 1'b0);
	endtask

	task automatic read_back();
		logic [ROM_BYTE_ADDR_W-1:0] a;
		for (int n = 0; n < NUM_READS; n++) begin
			if (rand_bits(2) != 0)
				a = written[rand_bits(8)] ^ ROM_BYTE_ADDR_W'(rand_bits(1)); // Either lane
			else
				a = rand_bits(ROM_BYTE_ADDR_W);
			rom_addr = a;
			@(negedge clock_48);
			check_value("rom_data", rom_data, rom_model[a]);
		end
	endtask

	task automatic pulse_reset_cause(input int cause);
		case (cause)
			0: status[ST_RESET] = 1'b1;
			1: reset_button = 1'b1;
			default: ioctl_download = 1'b1;
		endcase
		@(negedge clock_48);
		check_value("core_reset", core_reset, 1'b1);
		status[ST_RESET] = 1'b0;
		reset_button = 1'b0;
		ioctl_download = 1'b0;
		@(negedge clock_48);
		check_value("core_reset", core_reset, 1'b0);
	endtask

	task automatic sweep_dips();
		logic [23:0] want;
		for (int n = 0; n < NUM_DIP; n++) begin
			status = rand_bits(32);
			if (rand_bits(3) == 7)
				core_mod = 7'd8 + 7'(rand_bits(7) % 120);
			else
				core_mod = rand_bits(3);
			want = expected_dsw(core_mod, status);
			@(negedge clock_48);
			check_value("dsw0", dsw0, want[7:0]);
			check_value("dsw1", dsw1, want[15:8]);
			check_value("dsw2", dsw2, want[23:16]);
		end
	endtask

	task automatic sweep_joysticks();
		for (int n = 0; n < NUM_JOY; n++) begin
			joystick_0 = rand_bits(8);
			joystick_1 = rand_bits(8);
			status[ST_ROTATE] = rand_bits(1);
			@(negedge clock_48);
			check_value("inp0", inp0, expected_player(joystick_0, status[ST_ROTATE]));
			check_value("inp1", inp1, expected_player(joystick_1, status[ST_ROTATE]));
			check_value("inp2", inp2, expected_buttons(joystick_0, joystick_1));
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		status = 32'd0;
		core_mod = 7'd0;
		reset_button = 1'b0;
		joystick_0 = 8'd0;
		joystick_1 = 8'd0;
		rom_addr = '0;
		repeat (8) @(posedge clock_48);
		@(negedge clock_48);
		check_value("core_reset", core_reset, 1'b1);
		arst_n = 1'b1;
		@(negedge clock_48);
		check_value("dsw0", dsw0, 8'd0);
		check_value("dsw1", dsw1, 8'd0);
		check_value("dsw2", dsw2, 8'd0);
		check_value("inp0", inp0, 6'd0);
		check_value("inp1", inp1, 6'd0);
		check_value("inp2", inp2, 3'd0);
		repeat (4) begin
			@(negedge clock_48);
			check_value("core_reset", core_reset, 1'b1); // No ROM yet
		end
		run_download();
		read_back();
		for (int c = 0; c < 3; c++)
			pulse_reset_cause(c);
		sweep_dips();
		sweep_joysticks();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: logic/core_shell.sv
`timescale 1ns/1ps

module core_shell import core_shell_pkg::*; (
	input  logic                       clock_48,
	input  logic                       arst_n,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [ROM_BYTE_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic [31:0]                status,
	input  logic [6:0]                 core_mod,
	input  logic                       reset_button,
	input  logic [7:0]                 joystick_0,
	input  logic [7:0]                 joystick_1,
	input  logic [ROM_BYTE_ADDR_W-1:0] rom_addr,
	output logic [7:0]                 rom_data,
	output logic                       core_reset,
	output logic [7:0]                 dsw0,
	output logic [7:0]                 dsw1,
	output logic [7:0]                 dsw2,
	output logic [5:0]                 inp0,
	output logic [5:0]                 inp1,
	output logic [2:0]                 inp2
);

	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	logic [ROM_WORD_ADDR_W-1:0] wb_adr;
	logic [15:0] wb_dat_w;
	logic [1:0] wb_sel;

	rom_loader u_rom_loader (
		.clock_48       (clock_48),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wb_ack         (wb_ack),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w),
		.wb_sel         (wb_sel)
	);

	rom_store u_rom_store (
		.clock_48 (clock_48),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_ack   (wb_ack),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	reset_sequencer u_reset_sequencer (
		.clock_48       (clock_48),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.reset_request  (status[ST_RESET]), // Menu reset entry
		.reset_button   (reset_button),
		.core_reset     (core_reset),
		.rom_loaded     ()
	);

	dip_mapper u_dip_mapper (
		.clock_48 (clock_48),
		.arst_n   (arst_n),
		.core_mod (core_mod),
		.status   (status),
		.dsw0     (dsw0),
		.dsw1     (dsw1),
		.dsw2     (dsw2)
	);

	input_packer u_input_packer (
		.clock_48   (clock_48),
		.arst_n     (arst_n),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (status[ST_ROTATE]),
		.inp0       (inp0),
		.inp1       (inp1),
		.inp2       (inp2)
	);

endmodule

// File: logic/input_packer.sv
`timescale 1ns/1ps

module input_packer (
	input  logic       clock_48,
	input  logic       arst_n,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic       rotate,
	output logic [5:0] inp0,
	output logic [5:0] inp1,
	output logic [2:0] inp2
);

	// Game order fire B, fire A, left, down, right, up
	function automatic logic [5:0] pack_player(input logic [7:0] joy, input logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		if (rot) begin
			up    = joy[0]; // Stick turned 90 degrees
			right = joy[2];
			down  = joy[1];
			left  = joy[3];
		end else begin
			right = joy[0];
			left  = joy[1];
			down  = joy[2];
			up    = joy[3];
		end
		return {joy[5], joy[4], left, down, right, up};
	endfunction

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			inp0 <= 6'd0;
			inp1 <= 6'd0;
			inp2 <= 3'd0;
		end else begin
			inp0 <= pack_player(joystick_0, rotate);
			inp1 <= pack_player(joystick_1, rotate);
			inp2 <= {joystick_0[6] | joystick_1[6], joystick_1[7], joystick_0[7]}; // Shared coin
		end
	end

endmodule

// File: logic/dip_mapper.sv
`timescale 1ns/1ps

module dip_mapper import core_shell_pkg::*; (
	input  logic        clock_48,
	input  logic        arst_n,
	input  logic [6:0]  core_mod,
	input  logic [31:0] status,
	output logic [7:0]  dsw0,
	output logic [7:0]  dsw1,
	output logic [7:0]  dsw2
);

	game_variant_e variant;
	logic freeze;
	logic service;
	logic [7:0] dsw0_next;
	logic [7:0] dsw1_next;
	logic [7:0] dsw2_next;

	assign freeze  = status[ST_FREEZE];
	assign service = status[ST_SERVICE];

	always_comb begin
		case (core_mod)
			7'd0, 7'd1: variant = GAME_DRUAGA;
			7'd2:       variant = GAME_MAPPY;
			7'd3:       variant = GAME_DIGDUG2;
			7'd4:       variant = GAME_MOTOS;
			default:    variant = GAME_OTHER; // Grobda, Phozon and unknown
		endcase
	end

	// Cabinet bits left at 0, upright only
	always_comb begin
		dsw0_next = 8'd0;
		dsw1_next = 8'd0;
		dsw2_next = 8'd0;
		case (variant)
			GAME_DRUAGA: begin
				dsw0_next = {2'd0, status[ST_TLIVES_LO +: 2], 4'd0};
				dsw1_next = {7'd0, freeze};
				dsw2_next = {dsw1_next[3:0], service, 3'd0};
			end
			GAME_MAPPY: begin
				dsw0_next = {freeze, status[ST_MROUNDP], status[ST_MDEMO], 2'd0,
					status[ST_MRANK_LO +: 3]};
				dsw1_next = {status[ST_MLIVES_LO +: 2], status[ST_MEXTEND_LO +: 3], 3'd0};
				dsw2_next = {service, 3'd0, service, 3'd0};
			end
			GAME_DIGDUG2: begin
				dsw0_next = {2'd0, status[ST_DLIVES], 5'd0};
				dsw1_next = {4'd0, freeze, status[ST_DLEVEL],
					status[ST_DEXTEND_LO +: 2]};
				dsw2_next = {dsw1_next[3:0], service, 3'd0};
			end
			GAME_MOTOS: begin
				dsw0_next = {status[ST_ODEMO], status[ST_OEXTEND_LO +: 2], status[ST_ORANK],
					status[ST_OLIVES], 3'd0};
				dsw1_next = {service, 7'd0};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			dsw0 <= 8'd0;
			dsw1 <= 8'd0;
			dsw2 <= 8'd0;
		end else begin
			dsw0 <= dsw0_next;
			dsw1 <= dsw1_next;
			dsw2 <= dsw2_next;
		end
	end

endmodule

// File: logic/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clock_48,
	input  logic arst_n,
	input  logic ioctl_download,
	input  logic reset_request,
	input  logic reset_button,
	output logic core_reset,
	output logic rom_loaded
);

	logic download_d;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1; // Core held until ROM is in
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download)
				rom_loaded <= 1'b1; // End of download
			core_reset <= reset_request | reset_button | ioctl_download | ~rom_loaded;
		end
	end

endmodule

// File: logic/rom_store.sv
`timescale 1ns/1ps

module rom_store import core_shell_pkg::*; (
	input  logic                       clock_48,
	input  logic                       arst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [ROM_WORD_ADDR_W-1:0] wb_adr,
	input  logic [15:0]                wb_dat_w,
	input  logic [1:0]                 wb_sel,
	output logic                       wb_ack,
	input  logic [ROM_BYTE_ADDR_W-1:0] rom_addr,
	output logic [7:0]                 rom_data
);

	logic [15:0] mem [ROM_WORDS];
	logic [15:0] word_q;
	logic odd_q;
	logic wb_hit;

	assign wb_hit = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_hit;
	end

	// Byte lane writes
	always_ff @(posedge clock_48) begin
		if (wb_hit && wb_we) begin
			if (wb_sel[0])
				mem[wb_adr][7:0] <= wb_dat_w[7:0];
			if (wb_sel[1])
				mem[wb_adr][15:8] <= wb_dat_w[15:8];
		end
	end

	// CPU fetch, one cycle latency
	always_ff @(posedge clock_48) begin
		word_q <= mem[rom_addr[ROM_BYTE_ADDR_W-1:1]];
		odd_q  <= rom_addr[0];
	end

	assign rom_data = odd_q ? word_q[15:8] : word_q[7:0];

endmodule

// File: logic/rom_loader.sv
`timescale 1ns/1ps

module rom_loader import core_shell_pkg::*; (
	input  logic                       clock_48,
	input  logic                       arst_n,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [ROM_BYTE_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic                       wb_ack,
	output logic                       wb_cyc,
	output logic                       wb_stb,
	output logic                       wb_we,
	output logic [ROM_WORD_ADDR_W-1:0] wb_adr,
	output logic [15:0]                wb_dat_w,
	output logic [1:0]                 wb_sel
);

	loader_state_e state;
	logic wr_last;
	logic wr_rise;
	logic [ROM_BYTE_ADDR_W-1:0] addr_q;
	logic [7:0] byte_q;

	// New byte only taken when the bus is free
	assign wr_rise = ioctl_wr & ~wr_last & ioctl_download & (state == LD_IDLE);

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			wr_last <= 1'b0;
			state   <= LD_IDLE;
		end else begin
			wr_last <= ioctl_wr;
			case (state)
				LD_IDLE: begin
					if (wr_rise)
						state <= LD_BUS;
				end
				LD_BUS: begin
					if (wb_ack) // Cycle ends with ack
						state <= LD_IDLE;
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	// Byte and address held for the bus cycle
	always_ff @(posedge clock_48) begin
		if (wr_rise) begin
			addr_q <= ioctl_addr;
			byte_q <= ioctl_dout;
		end
	end

	assign wb_cyc   = (state == LD_BUS);
	assign wb_stb   = (state == LD_BUS);
	assign wb_we    = (state == LD_BUS); // Write only master
	assign wb_adr   = addr_q[ROM_BYTE_ADDR_W-1:1];
	assign wb_dat_w = {byte_q, byte_q};
	assign wb_sel   = {addr_q[0], ~addr_q[0]}; // Odd byte in high lane

endmodule

// File: logic/core_shell_pkg.sv
package core_shell_pkg;

	// ROM store geometry
	localparam int ROM_BYTE_ADDR_W = 12;
	localparam int ROM_WORD_ADDR_W = ROM_BYTE_ADDR_W - 1;
	localparam int ROM_WORDS       = 2048; // 16-bit words

	// Menu status word, shared switches
	localparam int ST_RESET   = 0;
	localparam int ST_ROTATE  = 2;
	localparam int ST_FREEZE  = 29;
	localparam int ST_SERVICE = 30;

	// Tower of Druaga
	localparam int ST_TLIVES_LO = 8;  // 2 bits

	// Mappy
	localparam int ST_MROUNDP    = 6;
	localparam int ST_MRANK_LO   = 10; // 3 bits
	localparam int ST_MDEMO      = 13;
	localparam int ST_MEXTEND_LO = 14; // 3 bits
	localparam int ST_MLIVES_LO  = 17; // 2 bits

	// Dig Dug II
	localparam int ST_DLIVES     = 19;
	localparam int ST_DEXTEND_LO = 20; // 2 bits
	localparam int ST_DLEVEL     = 22;

	// Motos
	localparam int ST_OLIVES     = 23;
	localparam int ST_ORANK      = 24;
	localparam int ST_OEXTEND_LO = 25; // 2 bits
	localparam int ST_ODEMO      = 27;

	typedef enum logic [2:0] {
		GAME_DRUAGA,
		GAME_MAPPY,
		GAME_DIGDUG2,
		GAME_MOTOS,
		GAME_OTHER
	} game_variant_e;

	typedef enum logic {
		LD_IDLE,
		LD_BUS
	} loader_state_e;

endpackage
